// File: run_sim.sh
#!/bin/sh
# build and run the conv_pixels testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_conv_pixels \
   -f verilog.f -o sim_conv_pixels
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim_conv_pixels)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1

// File: src/conv_cfg_axil.sv
module conv_cfg_axil import conv_tile_pkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   // write address, data and response
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [AXI_ADDR_W-1:0]   awaddr,
   input  logic                    wvalid,
   output logic                    wready,
   input  logic [AXI_DATA_W-1:0]   wdata,
   input  logic [AXI_DATA_W/8-1:0] wstrb,
   output logic                    bvalid,
   input  logic                    bready,
   output logic [1:0]              bresp,
   // read address and data
   input  logic                    arvalid,
   output logic                    arready,
   input  logic [AXI_ADDR_W-1:0]   araddr,
   output logic                    rvalid,
   input  logic                    rready,
   output logic [AXI_DATA_W-1:0]   rdata,
   output logic [1:0]              rresp,
   // tile control
   output logic                    start,
   input  logic                    stride_err,
   input  logic                    tile_done,
   input  logic [IDX_W-1:0]        seg_count,
   output logic [IDX_W-1:0]        ix,
   output logic [IDX_W-1:0]        pox,
   output logic [IDX_W-1:0]        ox_start,
   output logic [GEO_W-1:0]        k,
   output logic [GEO_W-1:0]        s,
   output logic [GEO_W-1:0]        p
);

   logic [AXI_DATA_W-1:0]   size_reg;
   logic [AXI_DATA_W-1:0]   win_reg;
   logic [AXI_DATA_W-1:0]   status;
   logic                    busy;
   logic                    done;

   logic                    aw_seen;
   logic                    w_seen;
   logic [AXI_ADDR_W-1:0]   wr_addr_q;
   logic [AXI_DATA_W-1:0]   wr_data_q;
   logic [AXI_DATA_W/8-1:0] wr_strb_q;

   logic                    aw_hs;
   logic                    w_hs;
   logic                    do_write;
   logic [AXI_ADDR_W-1:0]   wr_addr;
   logic [AXI_DATA_W-1:0]   wr_data;
   logic [AXI_DATA_W/8-1:0] wr_strb;

   ////////////////////
   // write channel

   assign awready = ~aw_seen & ~bvalid;
   assign wready  = ~w_seen & ~bvalid;
   assign aw_hs   = awvalid & awready;
   assign w_hs    = wvalid & wready;
   assign bresp   = RESP_OKAY;

   // address and data can come in either order
   assign wr_addr  = aw_seen ? wr_addr_q : awaddr;
   assign wr_data  = w_seen ? wr_data_q : wdata;
   assign wr_strb  = w_seen ? wr_strb_q : wstrb;
   assign do_write = (aw_seen | aw_hs) & (w_seen | w_hs);

   always_ff @(posedge clk) begin
      if (reset) begin
         aw_seen <= 1'b0;
         w_seen  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         aw_seen <= (aw_seen | aw_hs) & ~do_write;
         w_seen  <= (w_seen | w_hs) & ~do_write;
         if (do_write)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs)
         wr_addr_q <= awaddr;
      if (w_hs) begin
         wr_data_q <= wdata;
         wr_strb_q <= wstrb;
      end
   end

   // geometry is frozen while a tile runs
   always_ff @(posedge clk) begin
      if (do_write && !busy) begin
         for (int b = 0; b < AXI_DATA_W / 8; b++) begin
            if (wr_strb[b]) begin
               if (wr_addr == REG_SIZE)
                  size_reg[8*b +: 8] <= wr_data[8*b +: 8];
               if (wr_addr == REG_WIN)
                  win_reg[8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         start <= 1'b0;
         busy  <= 1'b0;
         done  <= 1'b0;
      end else begin
         start <= do_write && !busy && wr_addr == REG_CTRL && wr_strb[0]
                  && wr_data[CTRL_START];
         if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
         end else if (tile_done) begin
            busy <= 1'b0;
            done <= 1'b1;
         end else if (stride_err) begin
            busy <= 1'b0;
         end
      end
   end

   assign ix       = size_reg[IDX_W-1:0];
   assign pox      = size_reg[AXI_DATA_W-1:IDX_W];
   assign ox_start = win_reg[IDX_W-1:0];
   assign k        = win_reg[WIN_K_LSB +: GEO_W];
   assign s        = win_reg[WIN_S_LSB +: GEO_W];
   assign p        = win_reg[WIN_P_LSB +: GEO_W];

   ////////////////////
   // read channel

   always_comb begin
      status            = '0;
      status[STAT_DONE] = done;
      status[STAT_BUSY] = busy;
      status[STAT_ERR]  = stride_err;
   end

   assign arready = ~rvalid;
   assign rresp   = RESP_OKAY;

   always_ff @(posedge clk) begin
      if (reset)
         rvalid <= 1'b0;
      else if (arvalid && arready)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         case (araddr)
            REG_SIZE:  rdata <= size_reg;
            REG_WIN:   rdata <= win_reg;
            REG_CTRL:  rdata <= status;
            REG_COUNT: rdata <= {{(AXI_DATA_W-IDX_W){1'b0}}, seg_count};
            default:   rdata <= '0;
         endcase
      end
   end

   // a response needs both halves of the write
   a_bvalid_after_write: assert property (@(posedge clk) disable iff (reset)
      $rose(bvalid) |-> $past(aw_seen || aw_hs) && $past(w_seen || w_hs))
      else $error("bvalid raised without a write handshake");

endmodule

// File: src/conv_pixels_top.sv
module conv_pixels_top import conv_tile_pkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   // AXI4-Lite configuration
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [AXI_ADDR_W-1:0]   awaddr,
   input  logic                    wvalid,
   output logic                    wready,
   input  logic [AXI_DATA_W-1:0]   wdata,
   input  logic [AXI_DATA_W/8-1:0] wstrb,
   output logic                    bvalid,
   input  logic                    bready,
   output logic [1:0]              bresp,
   input  logic                    arvalid,
   output logic                    arready,
   input  logic [AXI_ADDR_W-1:0]   araddr,
   output logic                    rvalid,
   input  logic                    rready,
   output logic [AXI_DATA_W-1:0]   rdata,
   output logic [1:0]              rresp,
   // descriptor stream
   output logic                    seg_valid,
   input  logic                    seg_ready,
   output logic                    seg_last,
   output logic [IDX_W-1:0]        row_start_idx,
   output logic [IDX_W-1:0]        row_end_idx,
   output logic [IDX_W-1:0]        reg_start_idx,
   output logic [IDX_W-1:0]        reg_end_idx,
   output logic [GEO_W-1:0]        west_pad,
   output logic [GEO_W-1:0]        slab_num,
   output logic [GEO_W-1:0]        east_pad
);

   // configuration and status
   logic             start;
   logic             stride_err;
   logic             tile_done;
   logic [IDX_W-1:0] seg_count;
   logic [IDX_W-1:0] ix;
   logic [IDX_W-1:0] pox;
   logic [IDX_W-1:0] ox_start;
   logic [GEO_W-1:0] k;
   logic [GEO_W-1:0] s;
   logic [GEO_W-1:0] p;

   // decoded geometry
   logic             geom_valid;
   logic [GEO_W-1:0] left_pad;
   logic [GEO_W-1:0] right_pad;
   logic [GEO_W-1:0] overlap;
   logic [IDX_W-1:0] row_start_fix;
   logic [IDX_W-1:0] row_end_min_fix;
   logic [IDX_W-1:0] row_end_fix;

   // walker to result stage
   logic             walk_valid;
   logic             walk_ready;
   logic             walk_last;
   logic [IDX_W-1:0] walk_row_start_idx;
   logic [IDX_W-1:0] walk_row_end_idx;
   logic [IDX_W-1:0] walk_reg_start_idx;
   logic [IDX_W-1:0] walk_reg_end_idx;
   logic [GEO_W-1:0] walk_west_pad;
   logic [GEO_W-1:0] walk_slab_num;
   logic [GEO_W-1:0] walk_east_pad;

   conv_cfg_axil u_cfg (.*);

   conv_window_decode u_decode (.*);

   conv_segment_walker u_walker (
      .*,
      .row_start_idx (walk_row_start_idx),
      .row_end_idx   (walk_row_end_idx),
      .reg_start_idx (walk_reg_start_idx),
      .reg_end_idx   (walk_reg_end_idx),
      .west_pad      (walk_west_pad),
      .slab_num      (walk_slab_num),
      .east_pad      (walk_east_pad)
   );

   conv_segment_result u_result (.*);

endmodule

// File: src/conv_segment_result.sv
module conv_segment_result import conv_tile_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   // from the walker
   input  logic             walk_valid,
   output logic             walk_ready,
   input  logic             walk_last,
   input  logic [IDX_W-1:0] walk_row_start_idx,
   input  logic [IDX_W-1:0] walk_row_end_idx,
   input  logic [IDX_W-1:0] walk_reg_start_idx,
   input  logic [IDX_W-1:0] walk_reg_end_idx,
   input  logic [GEO_W-1:0] walk_west_pad,
   input  logic [GEO_W-1:0] walk_slab_num,
   input  logic [GEO_W-1:0] walk_east_pad,
   // descriptor stream
   output logic             seg_valid,
   input  logic             seg_ready,
   output logic             seg_last,
   output logic [IDX_W-1:0] row_start_idx,
   output logic [IDX_W-1:0] row_end_idx,
   output logic [IDX_W-1:0] reg_start_idx,
   output logic [IDX_W-1:0] reg_end_idx,
   output logic [GEO_W-1:0] west_pad,
   output logic [GEO_W-1:0] slab_num,
   output logic [GEO_W-1:0] east_pad,
   // status
   output logic             tile_done,
   output logic [IDX_W-1:0] seg_count
);

   logic [DESC_W-1:0] buf_mem [2];
   logic              wr_ptr;
   logic              rd_ptr;
   logic [1:0]        count;
   logic              push;
   logic              pop;

   // ready does not wait on the consumer, so no comb path back
   assign walk_ready = count != 2'd2;
   assign seg_valid  = count != 2'd0;
   assign push       = walk_valid & walk_ready;
   assign pop        = seg_valid & seg_ready;

   assign {seg_last, row_start_idx, row_end_idx, reg_start_idx, reg_end_idx,
           west_pad, slab_num, east_pad} = buf_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push)
         buf_mem[wr_ptr] <= {walk_last, walk_row_start_idx, walk_row_end_idx,
                             walk_reg_start_idx, walk_reg_end_idx,
                             walk_west_pad, walk_slab_num, walk_east_pad};
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= 1'b0;
         rd_ptr    <= 1'b0;
         count     <= 2'd0;
         tile_done <= 1'b0;
         seg_count <= '0;
      end else begin
         wr_ptr    <= wr_ptr ^ push;
         rd_ptr    <= rd_ptr ^ pop;
         count     <= count + {1'b0, push} - {1'b0, pop};
         tile_done <= pop & seg_last;
         if (pop)
            seg_count <= seg_count + 1'b1;
      end
   end

   // pointers apart by exactly the number of unread entries
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      count != 2'd3 && (wr_ptr ^ rd_ptr) == count[0])
      else $error("segment buffer overflow");

endmodule

// File: src/conv_segment_walker.sv
module conv_segment_walker import conv_tile_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  logic             geom_valid,
   input  logic [GEO_W-1:0] left_pad,
   input  logic [GEO_W-1:0] right_pad,
   input  logic [GEO_W-1:0] overlap,
   input  logic [IDX_W-1:0] row_start_fix,
   input  logic [IDX_W-1:0] row_end_min_fix,
   input  logic [IDX_W-1:0] row_end_fix,
   input  logic             walk_ready,
   output logic             walk_valid,
   output logic             walk_last,
   output logic [IDX_W-1:0] row_start_idx,
   output logic [IDX_W-1:0] row_end_idx,
   output logic [IDX_W-1:0] reg_start_idx,
   output logic [IDX_W-1:0] reg_end_idx,
   output logic [GEO_W-1:0] west_pad,
   output logic [GEO_W-1:0] slab_num,
   output logic [GEO_W-1:0] east_pad
);

   logic             phase2;
   logic [IDX_W-1:0] adr;
   logic [IDX_W-1:0] reg_from;
   logic [IDX_W-1:0] phase_base;
   logic [IDX_W-1:0] seg_limit;
   logic [IDX_W-1:0] seg_span;
   logic             has_phase2;
   logic             last_in_phase;
   logic             first_seg;

   ////////////////////
   // current descriptor

   // phase one covers the minimal span, phase two the rest of the kernel
   assign phase_base = phase2 ? row_end_min_fix + 1'b1 : row_start_fix;
   assign seg_limit  = phase2 ? row_end_fix : row_end_min_fix;
   assign has_phase2 = row_end_fix > row_end_min_fix;

   assign row_start_idx = phase_base + adr;
   assign last_in_phase = row_start_idx + IDX_W'(PIXELS_IN_ROW - 1) >= seg_limit;
   assign row_end_idx   = last_in_phase ? seg_limit
                                        : row_start_idx + IDX_W'(PIXELS_IN_ROW - 1);
   assign seg_span      = row_end_idx - row_start_idx;

   assign walk_last = last_in_phase && (phase2 || !has_phase2);
   assign first_seg = !phase2 && adr == '0;

   // pads only at the two tile edges
   assign west_pad = first_seg ? left_pad : '0;
   assign slab_num = first_seg ? overlap : '0;
   assign east_pad = walk_last ? right_pad : '0;

   assign reg_start_idx = reg_from;
   assign reg_end_idx   = reg_from + seg_span + IDX_W'(east_pad);

   ////////////////////
   // stepping

   always_ff @(posedge clk) begin
      if (reset) begin
         walk_valid <= 1'b0;
         phase2     <= 1'b0;
      end else if (geom_valid) begin
         walk_valid <= 1'b1;
         phase2     <= 1'b0;
      end else if (walk_valid && walk_ready) begin
         if (walk_last)
            walk_valid <= 1'b0;
         else if (last_in_phase)
            phase2 <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (geom_valid) begin
         adr      <= '0;
         reg_from <= IDX_W'(left_pad) + IDX_W'(overlap) + 1'b1;
      end else if (walk_valid && walk_ready) begin
         if (last_in_phase) begin
            // phase two builds on the last phase-one register
            adr      <= '0;
            reg_from <= reg_end_idx;
         end else begin
            adr      <= adr + IDX_W'(PIXELS_IN_ROW);
            reg_from <= reg_end_idx + 1'b1;
         end
      end
   end

   // an offered descriptor stays put until the result stage takes it
   a_hold_desc: assert property (@(posedge clk) disable iff (reset)
      walk_valid && !walk_ready |=> walk_valid && $stable(row_start_idx)
         && $stable(reg_start_idx) && $stable(reg_end_idx) && $stable(walk_last))
      else $error("walker descriptor changed while stalled");

endmodule

// File: src/conv_tile_pkg.sv
package conv_tile_pkg;

   // input buffer rows
   localparam int PIXELS_IN_ROW = 32;
   localparam int ROW_MASK_BITS = 5;

   // index and geometry field widths
   localparam int IDX_W = 16;
   localparam int GEO_W = 4;

   // descriptor as stored in the output buffer
   localparam int DESC_W = 1 + 4 * IDX_W + 3 * GEO_W;

   ////////////////////
   // register map

   localparam int AXI_ADDR_W = 4;
   localparam int AXI_DATA_W = 32;

   localparam logic [AXI_ADDR_W-1:0] REG_SIZE  = 4'h0;
   localparam logic [AXI_ADDR_W-1:0] REG_WIN   = 4'h4;
   localparam logic [AXI_ADDR_W-1:0] REG_CTRL  = 4'h8;
   localparam logic [AXI_ADDR_W-1:0] REG_COUNT = 4'hC;

   // ctrl and status bits
   localparam int CTRL_START = 0;
   localparam int STAT_DONE  = 1;
   localparam int STAT_BUSY  = 2;
   localparam int STAT_ERR   = 3;

   // nibble positions inside REG_WIN
   localparam int WIN_K_LSB = 16;
   localparam int WIN_S_LSB = 20;
   localparam int WIN_P_LSB = 24;

   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: src/conv_window_decode.sv
module conv_window_decode import conv_tile_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic [IDX_W-1:0] ix,
   input  logic [IDX_W-1:0] pox,
   input  logic [IDX_W-1:0] ox_start,
   input  logic [GEO_W-1:0] k,
   input  logic [GEO_W-1:0] s,
   input  logic [GEO_W-1:0] p,
   output logic             geom_valid,
   output logic             stride_err,
   output logic [GEO_W-1:0] left_pad,
   output logic [GEO_W-1:0] right_pad,
   output logic [GEO_W-1:0] overlap,
   output logic [IDX_W-1:0] row_start_fix,
   output logic [IDX_W-1:0] row_end_min_fix,
   output logic [IDX_W-1:0] row_end_fix
);

   logic             stride_ok;
   logic [IDX_W-1:0] pad;
   logic [IDX_W-1:0] pad_plus_1;
   logic [IDX_W-1:0] pad_plus_ix;
   logic [IDX_W-1:0] pox_m1;
   logic [IDX_W-1:0] step_span;
   logic [IDX_W-1:0] ix_start;
   logic [IDX_W-1:0] ix_end;
   logic [IDX_W-1:0] ix_end_min0;
   logic [IDX_W-1:0] ix_end_min;
   logic [IDX_W-1:0] lpad;
   logic [IDX_W-1:0] rpad;
   logic [IDX_W-1:0] rpad_min;
   logic [IDX_W-1:0] ovl;
   logic [IDX_W-1:0] row_end_raw;
   logic [IDX_W-1:0] row_end_min_raw;

   // last pixel of the buffer row holding v, clamped to the image
   function automatic logic [IDX_W-1:0] round_to_row(input logic [IDX_W-1:0] v,
                                                    input logic [IDX_W-1:0] width);
      logic [IDX_W-1:0] r;
      if (v[ROW_MASK_BITS-1:0] == '0)
         r = v - 1'b1;
      else
         r = v | IDX_W'(PIXELS_IN_ROW - 1);
      return (r > width - 1'b1) ? width - 1'b1 : r;
   endfunction

   assign stride_ok   = (s == GEO_W'(1)) || (s == GEO_W'(2));
   assign pad         = IDX_W'(p);
   assign pad_plus_1  = pad + 1'b1;
   assign pad_plus_ix = pad + ix;
   assign pox_m1      = pox - 1'b1;

   // (pox-1)*s and the first input column, strides 1 and 2 only
   assign step_span = (s == GEO_W'(2)) ? pox_m1 << 1 : pox_m1;
   assign ix_start  = (s == GEO_W'(2)) ? (ox_start << 1) - 1'b1 : ox_start;

   assign ix_end      = ix_start + step_span + IDX_W'(k) - 1'b1;
   assign ix_end_min0 = ix_start + step_span + 1'b1;
   assign ix_end_min  = (ix_end_min0 > ix_end) ? ix_end : ix_end_min0;

   assign lpad     = (ix_start <= pad) ? pad - ix_start + 1'b1 : '0;
   assign rpad     = (ix_end > pad_plus_ix) ? ix_end - pad_plus_ix : '0;
   assign rpad_min = (ix_end_min > pad_plus_ix) ? ix_end_min - pad_plus_ix : '0;
   assign ovl      = (ix_start <= pad_plus_1) ? '0 : pad;

   assign row_end_raw     = ix_end - rpad - pad_plus_1;
   assign row_end_min_raw = ix_end_min - rpad_min - pad_plus_1;

   always_ff @(posedge clk) begin
      if (reset) begin
         geom_valid <= 1'b0;
         stride_err <= 1'b0;
      end else begin
         geom_valid <= start && stride_ok;
         if (start)
            stride_err <= !stride_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         left_pad        <= lpad[GEO_W-1:0];
         right_pad       <= rpad[GEO_W-1:0];
         overlap         <= ovl[GEO_W-1:0];
         row_start_fix   <= ix_start + lpad - pad_plus_1 + ovl;
         row_end_min_fix <= round_to_row(row_end_min_raw, ix);
         row_end_fix     <= round_to_row(row_end_raw, ix);
      end
   end

endmodule

// File: verification/conv_pixels_checker.sv
module conv_pixels_checker import conv_tile_pkg::*; (
   input logic             clk,
   input logic             reset,
   input logic             seg_valid,
   input logic             seg_ready,
   input logic             seg_last,
   input logic [IDX_W-1:0] row_start_idx,
   input logic [IDX_W-1:0] row_end_idx,
   input logic [IDX_W-1:0] reg_start_idx,
   input logic [IDX_W-1:0] reg_end_idx,
   input logic [GEO_W-1:0] west_pad,
   input logic [GEO_W-1:0] slab_num,
   input logic [GEO_W-1:0] east_pad
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [DESC_W-1:0] exp_q [$];
   logic [DESC_W-1:0] got;
   logic [DESC_W-1:0] exp_d;
   int                error_count = 0;
   int                check_count = 0;
   int                tests_passed = 0;
   int                tests_failed = 0;
   int                errors_at_test = 0;
   int                test_index = 0;

   assign got = {seg_last, row_start_idx, row_end_idx, reg_start_idx, reg_end_idx,
                 west_pad, slab_num, east_pad};

   function automatic string describe(input logic [DESC_W-1:0] d);
      return $sformatf("rows %0d-%0d regs %0d-%0d west %0d slab %0d east %0d last %0d",
                       d[4*IDX_W+3*GEO_W-1 -: IDX_W], d[3*IDX_W+3*GEO_W-1 -: IDX_W],
                       d[2*IDX_W+3*GEO_W-1 -: IDX_W], d[IDX_W+3*GEO_W-1 -: IDX_W],
                       d[3*GEO_W-1 -: GEO_W], d[2*GEO_W-1 -: GEO_W], d[GEO_W-1:0],
                       d[DESC_W-1]);
   endfunction

   function void add_expected(input logic [DESC_W-1:0] d);
      exp_q.push_back(d);
   endfunction

   function int outstanding();
      return exp_q.size();
   endfunction

   function void check_value(input string what, input int got_v, input int exp_v);
      check_count++;
      if (got_v != exp_v) begin
         error_count++;
         $display("CHECK FAILED at %0t: %s read %0d, expected %0d", $time, what, got_v, exp_v);
      end
   endfunction

   function void end_test(input string name);
      test_index++;
      if (exp_q.size() != 0) begin
         error_count++;
         $display("%0d expected segments never arrived in %s", exp_q.size(), name);
         exp_q.delete();
      end
      if (error_count == errors_at_test) begin
         tests_passed++;
         $display("test %0d %s: ok", test_index, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", test_index, name, error_count - errors_at_test);
      end
      errors_at_test = error_count;
   endfunction

   function void print_counts();
      $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
               tests_passed, tests_failed, check_count, error_count);
   endfunction

   // one compare per accepted descriptor
   always @(posedge clk) begin
      if (!reset && seg_valid && seg_ready) begin
         if (exp_q.size() == 0) begin
            error_count++;
            $display("segment arrived at %0t with none expected: %s", $time, describe(got));
         end else begin
            exp_d = exp_q.pop_front();
            check_count++;
            if (got != exp_d) begin
               error_count++;
               $display("CHECK FAILED at %0t: segment %s, expected %s",
                        $time, describe(got), describe(exp_d));
            end
         end
      end
   end

endmodule

// File: verification/conv_pixels_input.txt
# T ix pox ox_start k s p
# S row_start row_end reg_start reg_end west_pad slab east_pad last
T 64 16 1 3 1 1
S 0 31 2 33 1 0 0 1
T 128 40 10 5 1 2
S 9 40 3 34 0 2 0 0
S 41 63 35 57 0 0 0 1
T 96 30 1 9 1 3
S 0 31 4 35 3 0 0 0
S 32 63 35 66 0 0 0 1
T 40 12 10 3 2 1
S 18 39 2 25 0 1 2 1
T 200 50 1 3 2 1
S 0 31 2 33 1 0 0 0
S 32 63 34 65 0 0 0 0
S 64 95 66 97 0 0 0 0
S 96 127 98 129 0 0 0 1
T 64 8 1 3 3 1

// File: verification/tb_conv_pixels.sv
module tb_conv_pixels import conv_tile_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_TESTS  = 16;
   localparam int MAX_SEGS   = 64;
   localparam int REG_BUDGET = 40;

   logic                    clk = 1'b0;
   logic                    reset;
   logic                    awvalid;
   logic                    awready;
   logic [AXI_ADDR_W-1:0]   awaddr;
   logic                    wvalid;
   logic                    wready;
   logic [AXI_DATA_W-1:0]   wdata;
   logic [AXI_DATA_W/8-1:0] wstrb;
   logic                    bvalid;
   logic                    bready;
   logic [1:0]              bresp;
   logic                    arvalid;
   logic                    arready;
   logic [AXI_ADDR_W-1:0]   araddr;
   logic                    rvalid;
   logic                    rready;
   logic [AXI_DATA_W-1:0]   rdata;
   logic [1:0]              rresp;
   logic                    seg_valid;
   logic                    seg_ready = 1'b0;
   logic                    seg_last;
   logic [IDX_W-1:0]        row_start_idx;
   logic [IDX_W-1:0]        row_end_idx;
   logic [IDX_W-1:0]        reg_start_idx;
   logic [IDX_W-1:0]        reg_end_idx;
   logic [GEO_W-1:0]        west_pad;
   logic [GEO_W-1:0]        slab_num;
   logic [GEO_W-1:0]        east_pad;

   // tile table from the data file
   int                cfg [MAX_TESTS][6];
   int                seg_first [MAX_TESTS];
   int                seg_num [MAX_TESTS];
   logic [DESC_W-1:0] seg_exp [MAX_SEGS];
   int                n_tests = 0;
   int                n_segs = 0;
   int                exp_count = 0;
   int                cycle_count = 0;
   int                cycle_limit = 0;

   conv_pixels_top u_dut (.*);

   conv_pixels_checker u_chk (.*);

   always #2 clk = ~clk;

   // consumer stalls about a quarter of the time
   initial begin
      void'($urandom(32'h1d4e3dec));
      forever begin
         @(posedge clk);
         seg_ready <= ($urandom % 4) != 0;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("run timed out after %0d cycles with %0d segments still outstanding",
                  cycle_count, u_chk.outstanding());
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // data file

   function automatic bit load_tests();
      int    fd;
      int    code;
      int    v [8];
      string line;
      byte   c;
      fd = $fopen("verification/conv_pixels_input.txt", "r");
      if (fd == 0)
         return 1'b0;
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code != 0 && line.len() > 0) begin
            c = line[0];
            if (c == "T") begin
               code = $sscanf(line, "T %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
               for (int i = 0; i < 6; i++)
                  cfg[n_tests][i] = v[i];
               seg_first[n_tests] = n_segs;
               seg_num[n_tests]   = 0;
               n_tests++;
            end else if (c == "S" && n_tests > 0) begin
               code = $sscanf(line, "S %d %d %d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
               seg_exp[n_segs] = {v[7][0], IDX_W'(v[0]), IDX_W'(v[1]), IDX_W'(v[2]),
                                  IDX_W'(v[3]), GEO_W'(v[4]), GEO_W'(v[5]), GEO_W'(v[6])};
               n_segs++;
               seg_num[n_tests-1]++;
            end
         end
      end
      $fclose(fd);
      return n_tests > 0;
   endfunction

   ////////////////////
   // AXI4-Lite

   task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
      bit aw_ok;
      bit w_ok;
      bit aw_hs;
      bit w_hs;
      aw_ok = 1'b0;
      w_ok  = 1'b0;
      @(posedge clk);
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wstrb   <= '1;
      bready  <= 1'b1;
      while (!(aw_ok && w_ok)) begin
         @(negedge clk);
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         @(posedge clk);
         if (aw_hs) begin
            awvalid <= 1'b0;
            aw_ok = 1'b1;
         end
         if (w_hs) begin
            wvalid <= 1'b0;
            w_ok = 1'b1;
         end
      end
      do @(negedge clk); while (!bvalid);
      u_chk.check_value("write response", int'(bresp), int'(RESP_OKAY));
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= addr;
      rready  <= 1'b1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      data = rdata;
      u_chk.check_value("read response", int'(rresp), int'(RESP_OKAY));
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic check_read(input logic [AXI_ADDR_W-1:0] addr, input int exp, input string what);
      logic [31:0] rd;
      axi_read(addr, rd);
      u_chk.check_value(what, int'(rd), exp);
   endtask

   ////////////////////
   // tests

   task automatic check_reset_state();
      @(negedge clk);
      u_chk.check_value("seg_valid after reset", int'(seg_valid), 0);
      check_read(REG_CTRL, 0, "status after reset");
      check_read(REG_COUNT, 0, "count after reset");
      u_chk.end_test("reset state");
   endtask

   task automatic run_tile(input int t);
      logic [31:0] size_word;
      logic [31:0] win_word;
      logic [31:0] rd;
      int          s;
      s         = cfg[t][4];
      size_word = {16'(cfg[t][1]), 16'(cfg[t][0])};
      win_word  = {4'h0, 4'(cfg[t][5]), 4'(s), 4'(cfg[t][3]), 16'(cfg[t][2])};
      axi_write(REG_SIZE, size_word);
      axi_write(REG_WIN, win_word);
      check_read(REG_SIZE, int'(size_word), "size readback");
      check_read(REG_WIN, int'(win_word), "window readback");
      for (int i = seg_first[t]; i < seg_first[t] + seg_num[t]; i++)
         u_chk.add_expected(seg_exp[i]);
      exp_count += seg_num[t];
      axi_write(REG_CTRL, 32'h1);
      do axi_read(REG_CTRL, rd); while (rd[STAT_BUSY]);
      // only strides 1 and 2 run, anything else flags an error
      if (s == 1 || s == 2) begin
         u_chk.check_value("done bit", int'(rd[STAT_DONE]), 1);
         u_chk.check_value("stride error bit", int'(rd[STAT_ERR]), 0);
      end else begin
         u_chk.check_value("done bit", int'(rd[STAT_DONE]), 0);
         u_chk.check_value("stride error bit", int'(rd[STAT_ERR]), 1);
      end
      check_read(REG_COUNT, exp_count, "segment count");
      u_chk.end_test($sformatf("tile %0d ix=%0d pox=%0d k=%0d s=%0d", t + 1,
                               cfg[t][0], cfg[t][1], cfg[t][3], s));
   endtask

   initial begin
      reset   = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      if (!load_tests()) begin
         $display("stimulus file missing or empty");
         $display("*** FAILED ***");
         $finish;
      end else begin
         // tile budget plus register traffic around each tile
         cycle_limit = 4 + REG_BUDGET * (n_tests + 1);
         for (int t = 0; t < n_tests; t++)
            cycle_limit += 20 + 8 * seg_num[t];
         repeat (4) @(posedge clk);
         reset <= 1'b0;
         check_reset_state();
         for (int t = 0; t < n_tests; t++)
            run_tile(t);
         repeat (2) @(posedge clk);
         u_chk.print_counts();
         if (u_chk.error_count == 0)
            $display("*** PASSED ***");
         else
            $display("*** FAILED ***");
         $finish;
      end
   end

endmodule

// File: verilog.f
src/conv_tile_pkg.sv
src/conv_cfg_axil.sv
src/conv_window_decode.sv
src/conv_segment_walker.sv
src/conv_segment_result.sv
src/conv_pixels_top.sv
verification/conv_pixels_checker.sv
verification/tb_conv_pixels.sv
